// ==== rtl/epriscCore_config.svh ====
// epRISC core configuration
`ifndef EPRISC_CORE_CONFIG_SVH
`define EPRISC_CORE_CONFIG_SVH

// Data and address width
`define EPRISC_XLEN 32

// General registers, register 0 reads as the instruction address
`define EPRISC_NUMREGS 16

// First fetch address after reset
`define EPRISC_RESETIP 32'h0000_0000

// Core operation that stops the sequencer
`define EPRISC_HALTOP 6'd2

`endif

// ==== rtl/epriscPkg.sv ====
// epRISC shared types
`include "epriscCore_config.svh"

package epriscPkg;

    typedef logic [`EPRISC_XLEN-1:0] word_t;
    typedef logic [$clog2(`EPRISC_NUMREGS)-1:0] regAddr_t;

    typedef enum logic [2:0] {
        clsBranch,
        clsLoad,
        clsStore,
        clsDirect,
        clsAlu,
        clsMove,
        clsCore,
        clsInvalid
    } instClass_t;

    // Codes as in the ISA, gaps are undefined
    typedef enum logic [4:0] {
        aluAdd    = 5'd0,
        aluSub    = 5'd1,
        aluAnd    = 5'd2,
        aluOr     = 5'd3,
        aluXor    = 5'd4,
        aluNot    = 5'd5,
        aluShl    = 5'd6,
        aluAsr    = 5'd7,
        aluLsr    = 5'd8,
        aluAndNot = 5'd11,
        aluAdc    = 5'd16,
        aluSbc    = 5'd17,
        aluSwap   = 5'd18
    } aluOp_t;

    typedef struct packed {
        logic carry;
        logic zero;
        logic negative;
        logic overflow;
    } condFlags_t;

    typedef enum logic [2:0] {
        stepFetch,
        stepDecode,
        stepExecute,
        stepMemory,
        stepWriteback,
        stepHalt
    } step_t;

endpackage

// ==== rtl/epriscRegFile.sv ====
// epRISC general register file
`include "epriscCore_config.svh"

module epriscRegFile (
    input  logic               iClk,
    input  epriscPkg::regAddr_t rdAddrA,
    input  epriscPkg::regAddr_t rdAddrB,
    output epriscPkg::word_t   rdDataA,
    output epriscPkg::word_t   rdDataB,
    input  logic               wrEn,
    input  epriscPkg::regAddr_t wrAddr,
    input  epriscPkg::word_t   wrData
);
    import epriscPkg::*;

    word_t regs [`EPRISC_NUMREGS];

    always_ff @(posedge iClk) begin
        if (wrEn) begin
            regs[wrAddr] <= wrData;
        end
    end

    // Both ports registered, data one cycle after the address
    always_ff @(posedge iClk) begin
        rdDataA <= regs[rdAddrA];
        rdDataB <= regs[rdAddrB];
    end

endmodule

// ==== rtl/epriscDecode.sv ====
// epRISC instruction decoder
module epriscDecode (
    input  epriscPkg::word_t      inst,
    output epriscPkg::instClass_t instClass,
    output epriscPkg::aluOp_t     aluOp,
    output epriscPkg::regAddr_t   srcA,
    output epriscPkg::regAddr_t   srcB,
    output epriscPkg::regAddr_t   dest,
    output epriscPkg::word_t      imm,
    output logic                  useImm,
    output logic                  orDirect,
    output logic [3:0]            cond,
    output logic [5:0]            coreOp
);
    import epriscPkg::*;

    // Class from the leading bits
    always_comb begin
        casez (inst[31:26])
            6'b1?????: instClass = (inst[30:28] == 3'b000) ? clsBranch : clsInvalid;
            6'b01????: instClass = inst[29] ? clsStore : clsLoad;
            6'b001???: instClass = clsDirect;
            6'b0001??: instClass = clsAlu;
            6'b00001?: instClass = inst[24] ? clsInvalid : clsMove;
            6'b000001: instClass = clsCore;
            default:   instClass = clsInvalid;
        endcase
    end

    assign aluOp    = aluOp_t'(inst[24:20]);
    assign cond     = inst[27:24];
    assign coreOp   = inst[25:20];
    assign useImm   = (instClass == clsAlu) && inst[27];
    assign orDirect = (instClass == clsDirect) && inst[28];

    always_comb begin
        srcA = '0;
        srcB = '0;
        dest = '0;
        imm  = '0;
        case (instClass)
            clsBranch: begin
                srcA = inst[23:20];
                imm  = word_t'($signed(inst[19:0]));
            end
            clsLoad, clsStore: begin
                srcA = inst[27:24];
                srcB = inst[23:20];
                dest = inst[23:20];
                imm  = word_t'(inst[19:0]);
            end
            clsDirect: begin
                srcA = inst[27:24];
                dest = inst[27:24];
                imm  = word_t'(inst[19:0]) << {inst[23:20], 1'b0};
            end
            clsAlu: begin
                srcA = inst[15:12];
                srcB = inst[11:8];
                dest = inst[19:16];
                // Shift field overlaps term B
                imm  = word_t'(inst[7:0]) << {inst[11:8], 1'b0};
            end
            clsMove: begin
                srcA = inst[19:16];
                srcB = inst[19:16];
                dest = inst[23:20];
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

// ==== rtl/epriscExecute.sv ====
// epRISC ALU and branch condition
module epriscExecute (
    input  logic                  iClk,
    input  logic                  reset,
    input  epriscPkg::step_t      step,
    input  epriscPkg::instClass_t instClass,
    input  epriscPkg::aluOp_t     aluOp,
    input  epriscPkg::word_t      opA,
    input  epriscPkg::word_t      opB,
    input  epriscPkg::word_t      imm,
    input  logic                  useImm,
    input  logic                  orDirect,
    input  logic [3:0]            cond,
    input  epriscPkg::condFlags_t flags,
    output epriscPkg::word_t      result,
    output logic                  carryOut,
    output logic                  taken
);
    import epriscPkg::*;

    localparam int wordBits = $bits(word_t);

    word_t              aluB;
    logic [wordBits:0]  aluOut;
    logic               condMet;

    assign aluB = useImm ? imm : opB;

    always_comb begin
        aluOut = '0;
        case (instClass)
            clsBranch, clsLoad, clsStore: aluOut = {1'b0, opA} + {1'b0, imm};
            clsDirect: aluOut = orDirect ? {1'b0, opA | imm} : {1'b0, imm};
            clsMove:   aluOut = {1'b0, opB};
            clsAlu: begin
                case (aluOp)
                    aluAdd:    aluOut = {1'b0, opA} + {1'b0, aluB};
                    aluSub:    aluOut = {1'b0, opA} - {1'b0, aluB};
                    aluAnd:    aluOut = {1'b0, opA & aluB};
                    aluOr:     aluOut = {1'b0, opA | aluB};
                    aluXor:    aluOut = {1'b0, opA ^ aluB};
                    aluNot:    aluOut = {1'b0, ~opA};
                    aluShl:    aluOut = {1'b0, opA << aluB};
                    aluAsr:    aluOut = {1'b0, word_t'($signed(opA) >>> aluB)};
                    aluLsr:    aluOut = {1'b0, opA >> aluB};
                    aluAndNot: aluOut = {1'b0, opA & ~aluB};
                    aluAdc:    aluOut = {1'b0, opA} + {1'b0, aluB} + flags.carry;
                    aluSbc:    aluOut = {1'b0, opA} - ({1'b0, aluB} + flags.carry);
                    aluSwap:   aluOut = {1'b0, opA[7:0], opA[15:8], opA[23:16], opA[31:24]};
                    default:   aluOut = '0;
                endcase
            end
            default: aluOut = '0;
        endcase
    end

    always_ff @(posedge iClk) begin
        if (reset) begin
            result   <= '0;
            carryOut <= 1'b0;
        end else if (step == stepExecute) begin
            {carryOut, result} <= aluOut;
        end
    end

    always_comb begin
        case (cond)
            4'd0:    condMet = 1'b1;
            4'd1:    condMet = flags.zero;
            4'd2:    condMet = !flags.zero;
            4'd3:    condMet = flags.carry;
            4'd4:    condMet = !flags.carry;
            4'd5:    condMet = flags.negative;
            4'd6:    condMet = !flags.negative;
            4'd7:    condMet = flags.overflow;
            4'd8:    condMet = !flags.overflow;
            4'd9:    condMet = flags.carry && !flags.zero;
            4'd10:   condMet = !flags.carry || flags.zero;
            4'd11:   condMet = flags.negative == flags.overflow;
            4'd12:   condMet = flags.negative != flags.overflow;
            4'd13:   condMet = !flags.zero && (flags.negative == flags.overflow);
            4'd14:   condMet = flags.zero || (flags.negative != flags.overflow);
            default: condMet = 1'b0;
        endcase
    end

    assign taken = (instClass == clsBranch) && condMet;

endmodule

// ==== rtl/epriscResult.sv ====
// epRISC writeback and flag update
`include "epriscCore_config.svh"

module epriscResult (
    input  logic                  iClk,
    input  logic                  reset,
    input  epriscPkg::step_t      step,
    input  epriscPkg::instClass_t instClass,
    input  epriscPkg::aluOp_t     aluOp,
    input  epriscPkg::regAddr_t   dest,
    input  logic [5:0]            coreOp,
    input  epriscPkg::word_t      result,
    input  logic                  carryOut,
    input  epriscPkg::word_t      opA,
    input  epriscPkg::word_t      opB,
    input  epriscPkg::word_t      loadData,
    input  logic                  taken,
    output epriscPkg::condFlags_t flags,
    output epriscPkg::word_t      ip,
    output logic                  wrEn,
    output epriscPkg::regAddr_t   wrAddr,
    output epriscPkg::word_t      wrData
);
    import epriscPkg::*;

    condFlags_t nextFlags;
    logic       isHalt;
    logic       msbA;
    logic       msbB;
    logic       msbR;

    assign isHalt = (instClass == clsCore) && (coreOp == `EPRISC_HALTOP);
    assign msbA   = opA[$bits(word_t)-1];
    assign msbB   = opB[$bits(word_t)-1];
    assign msbR   = result[$bits(word_t)-1];

    // Register 0 is the instruction pointer and never written here
    assign wrAddr = dest;
    assign wrData = (instClass == clsLoad) ? loadData : result;
    assign wrEn   = (step == stepWriteback) && (dest != '0) &&
                    (instClass inside {clsLoad, clsDirect, clsAlu, clsMove});

    always_comb begin
        nextFlags.carry    = (aluOp == aluAdd) ? carryOut :
                             (aluOp == aluSub) ? !carryOut : 1'b0;
        nextFlags.zero     = (result == '0);
        nextFlags.negative = msbR;
        nextFlags.overflow = ((aluOp == aluAdd) && (msbA == msbB) && (msbR != msbA)) ||
                             ((aluOp == aluSub) && (msbA != msbB) && (msbR != msbA));
    end

    always_ff @(posedge iClk) begin
        if (reset) begin
            flags <= '0;
            ip    <= word_t'(`EPRISC_RESETIP);
        end else if (step == stepWriteback) begin
            if (instClass == clsAlu) begin
                flags <= nextFlags;
            end
            if (taken) begin
                ip <= result;
            end else if (!isHalt) begin
                ip <= ip + 1'b1;
            end
        end
    end

endmodule

// ==== rtl/epriscCore.sv ====
// epRISC multicycle core
`include "epriscCore_config.svh"

module epriscCore (
    input  logic             iClk,
    input  logic             reset,
    output epriscPkg::word_t oAddr,
    output logic             oWrite,
    output epriscPkg::word_t oWData,
    input  epriscPkg::word_t iRData,
    input  logic             iReady,
    output logic             oHalt
);
    import epriscPkg::*;

    step_t      step;
    step_t      stepNext;
    word_t      instReg;
    word_t      loadData;
    instClass_t instClass;
    aluOp_t     aluOp;
    regAddr_t   srcA, srcB, dest, wrAddr;
    word_t      imm, rdDataA, rdDataB, opA, opB, flagOpB;
    word_t      result, ip, wrData;
    logic       useImm, orDirect, carryOut, taken, wrEn;
    logic       memAccess, isHalt;
    logic [3:0] cond;
    logic [5:0] coreOp;
    condFlags_t flags;

    assign memAccess = (instClass == clsLoad) || (instClass == clsStore);
    assign isHalt    = (instClass == clsCore) && (coreOp == `EPRISC_HALTOP);

    always_comb begin
        stepNext = step;
        case (step)
            stepFetch:     if (iReady) stepNext = stepDecode;
            stepDecode:    stepNext = stepExecute;
            stepExecute:   stepNext = stepMemory;
            stepMemory:    if (iReady || !memAccess) stepNext = stepWriteback;
            stepWriteback: stepNext = isHalt ? stepHalt : stepFetch;
            stepHalt:      stepNext = stepHalt;
            default:       stepNext = stepFetch;
        endcase
    end

    always_ff @(posedge iClk) begin
        if (reset) begin
            step <= stepFetch;
        end else begin
            step <= stepNext;
        end
    end

    always_ff @(posedge iClk) begin
        if (step == stepFetch && iReady) begin
            instReg <= iRData;
        end
        if (step == stepMemory && iReady && instClass == clsLoad) begin
            loadData <= iRData;
        end
    end

    // Register 0 reads as the current instruction address
    assign opA     = (srcA == '0) ? ip : rdDataA;
    assign opB     = (srcB == '0) ? ip : rdDataB;
    assign flagOpB = useImm ? imm : opB;

    assign oAddr  = (step == stepFetch) ? ip : result;
    assign oWrite = (step == stepMemory) && (instClass == clsStore);
    assign oWData = opB;
    assign oHalt  = (step == stepHalt);

    epriscDecode decode_i (
        .inst(instReg), .instClass(instClass), .aluOp(aluOp), .srcA(srcA), .srcB(srcB),
        .dest(dest), .imm(imm), .useImm(useImm), .orDirect(orDirect), .cond(cond),
        .coreOp(coreOp)
    );

    epriscRegFile regFile_i (
        .iClk(iClk), .rdAddrA(srcA), .rdAddrB(srcB), .rdDataA(rdDataA), .rdDataB(rdDataB),
        .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData)
    );

    epriscExecute execute_i (
        .iClk(iClk), .reset(reset), .step(step), .instClass(instClass), .aluOp(aluOp),
        .opA(opA), .opB(opB), .imm(imm), .useImm(useImm), .orDirect(orDirect),
        .cond(cond), .flags(flags), .result(result), .carryOut(carryOut), .taken(taken)
    );

    epriscResult result_i (
        .iClk(iClk), .reset(reset), .step(step), .instClass(instClass), .aluOp(aluOp),
        .dest(dest), .coreOp(coreOp), .result(result), .carryOut(carryOut), .opA(opA),
        .opB(flagOpB), .loadData(loadData), .taken(taken), .flags(flags), .ip(ip),
        .wrEn(wrEn), .wrAddr(wrAddr), .wrData(wrData)
    );

endmodule

// ==== tb/epriscCore_chk.sv ====
// epRISC bus and halt assertions
module epriscCore_chk (
    input logic             iClk,
    input logic             reset,
    input epriscPkg::word_t oAddr,
    input logic             oWrite,
    input epriscPkg::word_t oWData,
    input logic             iReady,
    input logic             oHalt
);
    timeunit 1ns;
    timeprecision 1ps;

    noWriteInHalt: assert property (@(posedge iClk) disable iff (reset) oHalt |-> !oWrite)
        else $error("store while halted");

    // Halt only leaves through reset
    haltSticky: assert property (@(posedge iClk) $fell(oHalt) |-> reset)
        else $error("halt dropped without reset");

    storeHeld: assert property (@(posedge iClk) disable iff (reset)
        (oWrite && !iReady) |=> ($stable(oAddr) && $stable(oWData)))
        else $error("store bus changed under wait");

endmodule

bind epriscCore epriscCore_chk chk_i (
    .iClk(iClk), .reset(reset), .oAddr(oAddr), .oWrite(oWrite), .oWData(oWData),
    .iReady(iReady), .oHalt(oHalt)
);

// ==== tb/epriscCoreTb.sv ====
// epRISC core testbench
`include "epriscCore_config.svh"

module epriscCoreTb;
    timeunit 1ns;
    timeprecision 1ps;
    import epriscPkg::*;

    localparam int progLen = 12;
    localparam int maxTests = 32;

    logic iClk, reset, iReady, oWrite, oHalt;
    word_t oAddr, oWData, iRData, lastAddr, lastData;
    word_t mem [256];
    int waitCnt, storeCount, numTests;
    word_t prog [maxTests][progLen];
    word_t expAddr [maxTests];
    word_t expVal [maxTests];
    int expStores [maxTests];

    epriscCore dut_i (
        .iClk(iClk), .reset(reset), .oAddr(oAddr), .oWrite(oWrite), .oWData(oWData),
        .iRData(iRData), .iReady(iReady), .oHalt(oHalt)
    );

    initial begin
        iClk = 1'b0;
        forever #5 iClk = ~iClk;
    end

    // Read data follows the address
    assign iRData = mem[oAddr[7:0]];

    // Ready pulses after a random wait
    initial begin
        void'($urandom(32'h0ce4_3a0c));
        forever begin
            @(posedge iClk);
            if (reset || iReady) begin
                iReady <= 1'b0;
                waitCnt <= $urandom % 4;
            end else if (waitCnt == 0) begin
                iReady <= 1'b1;
            end else begin
                waitCnt <= waitCnt - 1;
            end
        end
    end

    always @(posedge iClk) begin
        if (reset) begin
            storeCount <= 0;
        end else if (oWrite && iReady) begin
            mem[oAddr[7:0]] <= oWData;
            lastAddr <= oAddr;
            lastData <= oWData;
            storeCount <= storeCount + 1;
        end
    end

    function automatic word_t directInst(bit orIt, int rd, int sh, logic [19:0] val);
        return {3'b001, orIt, 4'(rd), 4'(sh), val};
    endfunction

    function automatic word_t aluInst(bit useImm, int op, int rd, int ra, int rb, int imm8);
        return {4'b0001, useImm, 2'b00, 5'(op), 4'(rd), 4'(ra), 4'(rb), 8'(imm8)};
    endfunction

    function automatic word_t memInst(bit store, int base, int rd, int off);
        return {2'b01, store, 1'b0, 4'(base), 4'(rd), 20'(off)};
    endfunction

    function automatic word_t branchInst(int cond, int off);
        return {4'b1000, 4'(cond), 4'd0, 20'(off)};
    endfunction

    function automatic word_t haltInst();
        return {6'b000001, 6'(`EPRISC_HALTOP), 20'd0};
    endfunction

    // A = 32'h8000_1234, B = 5 or immediate 3 shifted to 12, result stored at 0xC0
    task automatic addAlu(int op, bit useImm, word_t exp);
        prog[numTests] = '{default: '0};
        prog[numTests][0] = directInst(0, 1, 6, 20'h80001);
        prog[numTests][1] = directInst(1, 1, 0, 20'h00234);
        prog[numTests][2] = directInst(0, 2, 0, 20'h5);
        prog[numTests][3] = directInst(0, 4, 0, 20'hC0);
        prog[numTests][4] = useImm ? aluInst(1, op, 3, 1, 1, 3) : aluInst(0, op, 3, 1, 2, 0);
        prog[numTests][5] = memInst(1, 4, 3, 0);
        prog[numTests][6] = haltInst();
        expAddr[numTests] = 32'hC0;
        expVal[numTests] = exp;
        expStores[numTests] = 1;
        numTests++;
    endtask

    // Compare by subtract, then a branch picks the marker
    task automatic addBranch(word_t a, word_t b, int cond, bit isTaken);
        prog[numTests] = '{default: '0};
        prog[numTests][0] = directInst(0, 1, 6, a[31:12]);
        prog[numTests][1] = directInst(1, 1, 0, 20'(a[11:0]));
        prog[numTests][2] = directInst(0, 2, 6, b[31:12]);
        prog[numTests][3] = directInst(1, 2, 0, 20'(b[11:0]));
        prog[numTests][4] = directInst(0, 4, 0, 20'hC0);
        prog[numTests][5] = aluInst(0, 1, 3, 1, 2, 0);
        prog[numTests][6] = branchInst(cond, 3);
        prog[numTests][7] = directInst(0, 10, 0, 20'hAA);
        prog[numTests][8] = branchInst(0, 2);
        prog[numTests][9] = directInst(0, 10, 0, 20'hBB);
        prog[numTests][10] = memInst(1, 4, 10, 0);
        prog[numTests][11] = haltInst();
        expAddr[numTests] = 32'hC0;
        expVal[numTests] = isTaken ? 32'hBB : 32'hAA;
        expStores[numTests] = 1;
        numTests++;
    endtask

    task automatic failRun(string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1);
    endtask

    task automatic checkValue(string name, word_t got, word_t exp);
        if (got !== exp) begin
            failRun($sformatf("ERR %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic runEntry(int t);
        int cycles;
        @(posedge iClk);
        reset <= 1'b1;
        for (int i = 0; i < 256; i++) begin
            mem[i] = {8'h5A, 8'(i), 8'(~i), 8'(i * 3)};
        end
        for (int i = 0; i < progLen; i++) begin
            mem[i] = prog[t][i];
        end
        mem[8'h80] = 32'h1234_5678;
        repeat (10) @(posedge iClk);
        reset <= 1'b0;
        cycles = 0;
        @(negedge iClk);
        while (!oHalt) begin
            @(negedge iClk);
            cycles++;
            if (cycles > 2000) begin
                failRun($sformatf("core did not halt in test %0d", t));
            end
        end
        repeat (5) @(negedge iClk);
        checkValue("oHalt", word_t'(oHalt), 32'h1);
        checkValue("storeCount", word_t'(storeCount), word_t'(expStores[t]));
        checkValue("oAddr", lastAddr, expAddr[t]);
        checkValue("oWData", lastData, expVal[t]);
    endtask

    initial begin
        reset = 1'b1;
        iReady = 1'b0;
        numTests = 0;
        addAlu(0, 0, 32'h8000_1239);
        addAlu(1, 0, 32'h8000_122F);
        addAlu(2, 0, 32'h0000_0004);
        addAlu(3, 0, 32'h8000_1235);
        addAlu(4, 0, 32'h8000_1231);
        addAlu(5, 0, 32'h7FFF_EDCB);
        addAlu(6, 0, 32'h0002_4680);
        addAlu(7, 0, 32'hFC00_0091);
        addAlu(8, 0, 32'h0400_0091);
        addAlu(11, 0, 32'h8000_1230);
        addAlu(16, 0, 32'h8000_1239);
        addAlu(17, 0, 32'h8000_122F);
        addAlu(18, 0, 32'h3412_0080);
        addAlu(9, 0, 32'h0000_0000);
        addAlu(0, 1, 32'h8000_1240);
        addAlu(1, 1, 32'h8000_1228);
        addAlu(6, 1, 32'h0123_4000);
        addBranch(5, 5, 1, 1);
        addBranch(5, 5, 2, 0);
        addBranch(5, 5, 3, 1);
        addBranch(3, 5, 3, 0);
        addBranch(3, 5, 5, 1);
        addBranch(32'h8000_0000, 1, 7, 1);
        addBranch(3, 5, 7, 0);
        // Plain then OR-combining direct load
        prog[numTests] = '{default: '0};
        prog[numTests][0] = directInst(0, 3, 3, 20'h12345);
        prog[numTests][1] = directInst(1, 3, 0, 20'h00007);
        prog[numTests][2] = directInst(0, 4, 0, 20'hC0);
        prog[numTests][3] = memInst(1, 4, 3, 0);
        prog[numTests][4] = haltInst();
        expAddr[numTests] = 32'hC0;
        expVal[numTests] = 32'h0048_D147;
        expStores[numTests] = 1;
        numTests++;
        // Load, add, store, move, second store
        prog[numTests] = '{default: '0};
        prog[numTests][0] = directInst(0, 4, 0, 20'hC0);
        prog[numTests][1] = directInst(0, 5, 0, 20'h80);
        prog[numTests][2] = memInst(0, 5, 6, 0);
        prog[numTests][3] = directInst(0, 7, 0, 20'h10);
        prog[numTests][4] = aluInst(0, 0, 8, 6, 7, 0);
        prog[numTests][5] = memInst(1, 4, 8, 0);
        prog[numTests][6] = {5'b00001, 3'b000, 4'd9, 4'd8, 16'd0};
        prog[numTests][7] = memInst(1, 4, 9, 1);
        prog[numTests][8] = haltInst();
        expAddr[numTests] = 32'hC1;
        expVal[numTests] = 32'h1234_5688;
        expStores[numTests] = 2;
        numTests++;
        // Second pass sees other ready delays
        for (int pass = 0; pass < 2; pass++) begin
            for (int t = 0; t < numTests; t++) begin
                runEntry(t);
            end
        end
        $display("TB PASSED");
        $finish;
    end

endmodule

// ==== list.f ====
+incdir+rtl
rtl/epriscPkg.sv
rtl/epriscRegFile.sv
rtl/epriscDecode.sv
rtl/epriscExecute.sv
rtl/epriscResult.sv
rtl/epriscCore.sv
tb/epriscCore_chk.sv
tb/epriscCoreTb.sv

// ==== Bender.yml ====
package:
  name: epriscCore

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/epriscPkg.sv
      - rtl/epriscRegFile.sv
      - rtl/epriscDecode.sv
      - rtl/epriscExecute.sv
      - rtl/epriscResult.sv
      - rtl/epriscCore.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - tb/epriscCore_chk.sv
      - tb/epriscCoreTb.sv
